// File: Makefile
TOP := eeprom_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timescale 1ns/1ns +incdir+common \
		common/eeprom_pkg.sv common/i2c_bit_if.sv common/byte_op_if.sv \
		eeprom_ctrl/eeprom_ctrl.sv logic/byte_shifter.sv \
		logic/i2c_bit_engine.sv logic/eeprom_top.sv \
		--top-module eeprom_top

sim:
	verilator --binary --timing --timescale 1ns/1ns -f all.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: all.f
+incdir+common
common/eeprom_pkg.sv
common/i2c_bit_if.sv
common/byte_op_if.sv
eeprom_ctrl/eeprom_ctrl.sv
logic/byte_shifter.sv
logic/i2c_bit_engine.sv
logic/eeprom_top.sv
tb/eeprom_model.sv
tb/eeprom_tb.sv

// File: common/byte_op_if.sv
`timescale 1ns/1ns

interface byte_op_if import eeprom_pkg::*; ();

    logic       valid;
    byte_op_e   op;
    logic [7:0] tx_byte;
    logic       send_nack;  // ack level sent after OP_RECV
    logic       ready;
    logic       done;
    logic [7:0] rx_byte;
    logic       rx_nack;    // ack level seen after OP_SEND

    modport master (
        output valid, op, tx_byte, send_nack,
        input  ready, done, rx_byte, rx_nack
    );

    modport slave (
        input  valid, op, tx_byte, send_nack,
        output ready, done, rx_byte, rx_nack
    );

endinterface

// File: common/eeprom_pkg.sv
package eeprom_pkg;

    // single bus commands, BIT_START doubles as repeated start
    typedef enum logic [1:0] {
        BIT_START = 2'd0,
        BIT_STOP  = 2'd1,
        BIT_WRITE = 2'd2,
        BIT_READ  = 2'd3
    } bit_cmd_e;

    // byte level operations
    typedef enum logic [1:0] {
        OP_START = 2'd0,
        OP_STOP  = 2'd1,
        OP_SEND  = 2'd2,   // 8 bits out, ack in
        OP_RECV  = 2'd3    // 8 bits in, ack out
    } byte_op_e;

    // controller transaction steps
    typedef enum logic [3:0] {
        IDLE    = 4'd0,
        START   = 4'd1,
        CTRL_W  = 4'd2,
        ADDR    = 4'd3,
        DATA_W  = 4'd4,
        RESTART = 4'd5,
        CTRL_R  = 4'd6,
        DATA_R  = 4'd7,
        STOP    = 4'd8,
        RESPOND = 4'd9
    } ctrl_state_e;

endpackage

// File: common/eeprom_settings.svh
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// CLK cycles per quarter of an SCL period
`define EEPROM_SCL_QUARTER 2

// 24C16 device type code, upper nibble of the control byte
`define EEPROM_DEVICE_CODE 4'b1010

// 2048 bytes
`define EEPROM_ADDR_W 11

`endif

// File: common/i2c_bit_if.sv
`timescale 1ns/1ns

interface i2c_bit_if import eeprom_pkg::*; ();

    logic     valid;
    bit_cmd_e cmd;
    logic     tx_bit;
    logic     ready;
    logic     done;    // one cycle pulse
    logic     rx_bit;  // good with done on BIT_READ

    modport master (
        output valid, cmd, tx_bit,
        input  ready, done, rx_bit
    );

    modport slave (
        input  valid, cmd, tx_bit,
        output ready, done, rx_bit
    );

endinterface

// File: eeprom_ctrl/eeprom_ctrl.sv
`timescale 1ns/1ns
`include "eeprom_settings.svh"

module eeprom_ctrl import eeprom_pkg::*; (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic                      req_write,
    input  logic [`EEPROM_ADDR_W-1:0] req_addr,
    input  logic [7:0]                req_data,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output logic [7:0]                rsp_data,
    output logic                      rsp_nack,
    byte_op_if.master                 op_bus
);

    ctrl_state_e               state;
    ctrl_state_e               next_state;
    logic                      pending;   // op accepted, waiting for done
    logic                      nack_r;
    logic                      ack_fail;
    logic                      write_r;
    logic [`EEPROM_ADDR_W-1:0] addr_r;
    logic [7:0]                data_r;
    logic [7:0]                rsp_data_r;

    assign req_ready = (state == IDLE);
    assign rsp_valid = (state == RESPOND);
    assign rsp_data  = rsp_data_r;
    assign rsp_nack  = nack_r;

    assign op_bus.valid = (state != IDLE) && (state != RESPOND) && !pending;

    // byte operation for the current step
    always_comb begin
        op_bus.op        = OP_SEND;
        op_bus.tx_byte   = 8'h00;
        op_bus.send_nack = 1'b0;
        case (state)
            START, RESTART: op_bus.op = OP_START;
            STOP:           op_bus.op = OP_STOP;
            CTRL_W: op_bus.tx_byte = {`EEPROM_DEVICE_CODE, addr_r[`EEPROM_ADDR_W-1:8], 1'b0};
            ADDR:   op_bus.tx_byte = addr_r[7:0];
            DATA_W: op_bus.tx_byte = data_r;
            CTRL_R: op_bus.tx_byte = {`EEPROM_DEVICE_CODE, addr_r[`EEPROM_ADDR_W-1:8], 1'b1};
            DATA_R: begin
                op_bus.op        = OP_RECV;
                op_bus.send_nack = 1'b1;  // single byte read ends with nack
            end
            default: ;
        endcase
    end

    assign ack_fail = op_bus.rx_nack && (op_bus.op == OP_SEND);

    always_comb begin
        next_state = state;
        case (state)
            START:   next_state = CTRL_W;
            CTRL_W:  next_state = ack_fail ? STOP : ADDR;
            ADDR: begin
                if (ack_fail)
                    next_state = STOP;
                else
                    next_state = write_r ? DATA_W : RESTART;
            end
            DATA_W:  next_state = STOP;
            RESTART: next_state = CTRL_R;
            CTRL_R:  next_state = ack_fail ? STOP : DATA_R;
            DATA_R:  next_state = STOP;
            STOP:    next_state = RESPOND;
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= IDLE;
            pending <= 1'b0;
            nack_r  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        state  <= START;
                        nack_r <= 1'b0;
                    end
                end
                RESPOND: begin
                    if (rsp_ready)
                        state <= IDLE;
                end
                default: begin
                    if (op_bus.valid && op_bus.ready)
                        pending <= 1'b1;
                    if (op_bus.done) begin
                        pending <= 1'b0;
                        state   <= next_state;
                        if (ack_fail)
                            nack_r <= 1'b1;
                    end
                end
            endcase
        end
    end

    // request latch and read result
    always_ff @(posedge CLK) begin
        if (state == IDLE && req_valid) begin
            write_r    <= req_write;
            addr_r     <= req_addr;
            data_r     <= req_data;
            rsp_data_r <= 8'h00;
        end else if (state == DATA_R && op_bus.done) begin
            rsp_data_r <= op_bus.rx_byte;
        end
    end

endmodule

// File: logic/byte_shifter.sv
`timescale 1ns/1ns

module byte_shifter import eeprom_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    byte_op_if.slave  op_bus,
    i2c_bit_if.master bit_bus
);

    byte_op_e   cur_op;
    logic       busy;
    logic       bit_valid;
    logic [3:0] bit_cnt;
    logic [7:0] shift_reg;
    logic       ack_bit;
    logic       nack_r;
    logic       done_r;
    logic       data_phase;
    logic       last_bit;

    assign data_phase = (bit_cnt < 4'd8);  // ninth bit is the ack
    assign last_bit   = (cur_op == OP_START) || (cur_op == OP_STOP) || !data_phase;

    assign op_bus.ready   = !busy;
    assign op_bus.done    = done_r;
    assign op_bus.rx_byte = shift_reg;
    assign op_bus.rx_nack = nack_r;

    assign bit_bus.valid  = bit_valid;
    assign bit_bus.tx_bit = (cur_op == OP_SEND) ? shift_reg[7] : ack_bit;

    always_comb begin
        case (cur_op)
            OP_START: bit_bus.cmd = BIT_START;
            OP_STOP:  bit_bus.cmd = BIT_STOP;
            OP_SEND:  bit_bus.cmd = data_phase ? BIT_WRITE : BIT_READ;
            default:  bit_bus.cmd = data_phase ? BIT_READ : BIT_WRITE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy      <= 1'b0;
            bit_valid <= 1'b0;
            bit_cnt   <= 4'd0;
            done_r    <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (!busy && op_bus.valid) begin
                busy      <= 1'b1;
                bit_valid <= 1'b1;
                bit_cnt   <= 4'd0;
            end else if (bit_valid && bit_bus.ready) begin
                bit_valid <= 1'b0;
            end else if (bit_bus.done) begin
                if (last_bit) begin
                    busy   <= 1'b0;
                    done_r <= 1'b1;
                end else begin
                    bit_cnt   <= bit_cnt + 4'd1;
                    bit_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!busy && op_bus.valid) begin
            cur_op    <= op_bus.op;
            shift_reg <= op_bus.tx_byte;
            ack_bit   <= op_bus.send_nack;
        end else if (bit_bus.done && data_phase) begin
            shift_reg <= {shift_reg[6:0], bit_bus.rx_bit};  // msb first
        end else if (bit_bus.done && cur_op == OP_SEND) begin
            nack_r <= bit_bus.rx_bit;
        end
    end

endmodule

// File: logic/eeprom_top.sv
`timescale 1ns/1ns
`include "eeprom_settings.svh"

module eeprom_top (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic                      req_write,
    input  logic [`EEPROM_ADDR_W-1:0] req_addr,
    input  logic [7:0]                req_data,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output logic [7:0]                rsp_data,
    output logic                      rsp_nack,
    output logic                      scl,
    output logic                      sda_low,  // high pulls SDA to 0
    input  logic                      sda_in
);

    byte_op_if op_bus ();
    i2c_bit_if bit_bus ();

    eeprom_ctrl eeprom_ctrl_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .rsp_nack  (rsp_nack),
        .op_bus    (op_bus.master)
    );

    byte_shifter byte_shifter_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .op_bus  (op_bus.slave),
        .bit_bus (bit_bus.master)
    );

    i2c_bit_engine i2c_bit_engine_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .bit_bus (bit_bus.slave),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda_in)
    );

endmodule

// File: logic/i2c_bit_engine.sv
`timescale 1ns/1ns
`include "eeprom_settings.svh"

module i2c_bit_engine import eeprom_pkg::*; (
    input  logic     CLK,
    input  logic     RESET,
    i2c_bit_if.slave bit_bus,
    output logic     scl,
    output logic     sda_low,
    input  logic     sda_in
);

    localparam int QUARTER = `EEPROM_SCL_QUARTER;
    localparam int QW = (QUARTER > 1) ? $clog2(QUARTER) : 1;

    bit_cmd_e      cur_cmd;
    logic          cur_bit;
    logic          busy;
    logic [1:0]    phase;
    logic [QW-1:0] q_cnt;
    logic          q_last;
    logic          rx_r;

    // scl per quarter
    function automatic logic scl_level(bit_cmd_e cmd, logic [1:0] ph);
        logic lvl;
        if (cmd == BIT_STOP)
            lvl = (ph != 2'd0);  // stays high, bus idle
        else
            lvl = (ph == 2'd1) || (ph == 2'd2);
        return lvl;
    endfunction

    // pull-down on sda per quarter
    function automatic logic sda_level(bit_cmd_e cmd, logic [1:0] ph, logic b);
        logic lvl;
        case (cmd)
            BIT_START: lvl = (ph >= 2'd2);  // falls while scl high
            BIT_STOP:  lvl = (ph < 2'd2);   // rises while scl high
            BIT_WRITE: lvl = !b;
            default:   lvl = 1'b0;
        endcase
        return lvl;
    endfunction

    assign q_last = (q_cnt == QW'(QUARTER - 1));

    assign bit_bus.ready  = !busy;
    assign bit_bus.done   = busy && q_last && (phase == 2'd3);
    assign bit_bus.rx_bit = rx_r;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy    <= 1'b0;
            phase   <= 2'd0;
            q_cnt   <= '0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
        end else if (!busy) begin
            if (bit_bus.valid) begin
                busy    <= 1'b1;
                phase   <= 2'd0;
                q_cnt   <= '0;
                scl     <= scl_level(bit_bus.cmd, 2'd0);
                sda_low <= sda_level(bit_bus.cmd, 2'd0, bit_bus.tx_bit);
            end
        end else if (q_last) begin
            q_cnt <= '0;
            if (phase == 2'd3) begin
                busy <= 1'b0;  // levels hold until next command
            end else begin
                phase   <= phase + 2'd1;
                scl     <= scl_level(cur_cmd, phase + 2'd1);
                sda_low <= sda_level(cur_cmd, phase + 2'd1, cur_bit);
            end
        end else begin
            q_cnt <= q_cnt + QW'(1);
        end
    end

    always_ff @(posedge CLK) begin
        if (!busy && bit_bus.valid) begin
            cur_cmd <= bit_bus.cmd;
            cur_bit <= bit_bus.tx_bit;
        end
        // middle of the scl high time
        if (busy && q_last && phase == 2'd1 && cur_cmd == BIT_READ)
            rx_r <= sda_in;
    end

endmodule

// File: tb/eeprom_model.sv
`timescale 1ns/1ns

module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic refuse,    // no ack on the control byte
    output logic sda_low,
    output logic in_frame,
    output logic code_err,
    output int   starts
);

    typedef enum int {M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_RDATA} mode_e;

    logic [7:0] mem [0:2047];
    logic [7:0] shift = 8'h00;
    logic [7:0] rd_byte = 8'h00;
    logic [2:0] addr_hi = 3'd0;
    logic [7:0] addr_lo = 8'h00;
    logic       drive_low = 1'b0;
    logic       framed = 1'b0;
    logic       bad_code = 1'b0;
    logic       prev_scl = 1'b0;
    logic       prev_sda = 1'b0;
    int         start_cnt = 0;
    int         bit_cnt = 0;      // scl rises seen in this byte, 9th is the ack
    mode_e      mode = M_IDLE;
    mode_e      next_mode = M_IDLE;

    assign sda_low  = drive_low;
    assign in_frame = framed;
    assign code_err = bad_code;
    assign starts   = start_cnt;

    initial begin
        for (int i = 0; i < 2048; i++)
            mem[11'(i)] = 8'(i) ^ 8'(i >> 3);
    end

    always @(scl or sda) begin
        if (prev_scl === 1'b1 && scl === 1'b1 && prev_sda === 1'b1 && sda === 1'b0) begin
            if (!framed) begin  // a repeated start keeps the frame open
                framed    = 1'b1;
                start_cnt = start_cnt + 1;
            end
            mode      = M_CTRL;
            bit_cnt   = 0;
            drive_low = 1'b0;
        end else if (prev_scl === 1'b1 && scl === 1'b1 && prev_sda === 1'b0 && sda === 1'b1) begin
            framed    = 1'b0;  // stop
            mode      = M_IDLE;
            drive_low = 1'b0;
        end else if (prev_scl === 1'b0 && scl === 1'b1) begin
            if (mode != M_IDLE && mode != M_RDATA && bit_cnt < 8)
                shift = {shift[6:0], sda};
            if (mode != M_IDLE)
                bit_cnt = bit_cnt + 1;
        end else if (prev_scl === 1'b1 && scl === 1'b0) begin
            if (bit_cnt == 8 && mode != M_RDATA && mode != M_IDLE) begin
                case (mode)
                    M_CTRL: begin
                        addr_hi = shift[3:1];
                        if (shift[7:4] != 4'b1010)
                            bad_code = 1'b1;
                        if (refuse || shift[7:4] != 4'b1010) begin
                            next_mode = M_IDLE;
                        end else if (shift[0]) begin
                            next_mode = M_RDATA;
                            rd_byte   = mem[{addr_hi, addr_lo}];
                        end else begin
                            next_mode = M_ADDR;
                        end
                        drive_low = (next_mode != M_IDLE);
                    end
                    M_ADDR: begin
                        addr_lo   = shift;
                        next_mode = M_WDATA;
                        drive_low = 1'b1;
                    end
                    default: begin
                        mem[{addr_hi, addr_lo}] = shift;
                        next_mode = M_IDLE;
                        drive_low = 1'b1;
                    end
                endcase
            end else if (bit_cnt == 9) begin
                bit_cnt   = 0;  // ack bit over
                drive_low = 1'b0;
                mode      = next_mode;
            end
            if (mode == M_RDATA && bit_cnt < 8) begin
                drive_low = !rd_byte[7];  // msb first
                rd_byte   = rd_byte << 1;
            end else if (mode == M_RDATA) begin
                drive_low = 1'b0;   // master answers
                next_mode = M_IDLE;
            end
        end
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

// File: tb/eeprom_stimulus.txt
// kind(0 wr 1 rd) addr data model_nack exp_data exp_nack, all hex
0 005 3c 0 00 0
0 1a7 81 0 00 0
0 2f0 5a 0 00 0
0 333 c3 0 00 0
0 4ff 01 0 00 0
0 580 fe 0 00 0
0 6aa 77 0 00 0
0 7ff a5 0 00 0
0 2f0 96 0 00 0
0 1a7 ee 1 00 1
1 333 00 1 00 1
1 005 00 0 3c 0
1 1a7 00 0 81 0
1 2f0 00 0 96 0
1 333 00 0 c3 0
1 4ff 00 0 01 0
1 580 00 0 fe 0
1 6aa 00 0 77 0
1 7ff 00 0 a5 0

// File: tb/eeprom_tb.sv
`timescale 1ns/1ns
`include "eeprom_settings.svh"

module eeprom_tb;

    logic        CLK;
    logic        RESET;
    logic        req_valid;
    logic        req_ready;
    logic        req_write;
    logic [10:0] req_addr;
    logic [7:0]  req_data;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [7:0]  rsp_data;
    logic        rsp_nack;
    logic        scl;
    logic        sda_low;
    logic        slave_low;
    logic        sda;
    logic        refuse;
    logic        in_frame;
    logic        code_err;
    int          frame_starts;
    int          scl_high = 0;  // falling edges seen with scl high
    logic [7:0]  ref_mem [0:2047];

    assign sda = !(sda_low || slave_low);  // pulled up unless someone pulls low

    eeprom_top eeprom_top_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .rsp_nack  (rsp_nack),
        .scl       (scl),
        .sda_low   (sda_low),
        .sda_in    (sda)
    );

    eeprom_model eeprom_model_inst (
        .scl      (scl),
        .sda      (sda),
        .refuse   (refuse),
        .sda_low  (slave_low),
        .in_frame (in_frame),
        .code_err (code_err),
        .starts   (frame_starts)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %0h expected %0h",
                     $time, what, actual, expected);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // every scl high pulse inside a frame lasts two quarters
    always @(negedge CLK) begin
        if (scl === 1'b1) begin
            scl_high = scl_high + 1;
        end else begin
            if (scl_high != 0 && in_frame === 1'b1)
                check_value(scl_high, 2 * `EEPROM_SCL_QUARTER, "scl high time of one bit");
            scl_high = 0;
        end
    end

    task automatic wait_req_ready();
        int cycles;
        cycles = 0;
        while (req_ready !== 1'b1) begin
            @(negedge CLK);
            cycles++;
            if (cycles >= 2000) begin
                $display("timeout: req_ready stayed low for 2000 cycles");
                $display("TEST FAIL");
                $fatal(1);
            end
        end
    endtask

    task automatic wait_rsp_valid();
        int cycles;
        cycles = 0;
        while (rsp_valid !== 1'b1) begin
            @(negedge CLK);
            cycles++;
            if (cycles >= 2000) begin
                $display("timeout: no response within 2000 cycles, controller in %s",
                         eeprom_top_inst.eeprom_ctrl_inst.state.name());
                $display("TEST FAIL");
                $fatal(1);
            end
        end
    endtask

    initial begin
        int         fd;
        int         kind;
        int         addr;
        int         data;
        int         mnack;
        int         exp_data;
        int         exp_nack;
        int         count;
        logic [7:0] held_data;
        logic       held_nack;
        string      header;

        RESET     = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = 11'd0;
        req_data  = 8'h00;
        rsp_ready = 1'b0;
        refuse    = 1'b0;
        count     = 0;
        for (int i = 0; i < 2048; i++)
            ref_mem[11'(i)] = 8'(i) ^ 8'(i >> 3);  // same fill as the model

        fd = $fopen("tb/eeprom_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/eeprom_stimulus.txt");
            $display("TEST FAIL");
            $fatal(1);
        end
        void'($fgets(header, fd));  // column line

        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        check_value(32'(scl), 1, "scl after reset");
        check_value(32'(sda_low), 0, "sda_low after reset");
        check_value(32'(req_ready), 1, "req_ready after reset");
        check_value(32'(rsp_valid), 0, "rsp_valid after reset");

        while ($fscanf(fd, " %h %h %h %h %h %h", kind, addr, data, mnack,
                       exp_data, exp_nack) == 6) begin
            check_value(exp_nack, mnack, "stimulus expected nack");
            if (kind == 1 && mnack == 0)
                check_value(exp_data, 32'(ref_mem[11'(addr)]), "stimulus expected read data");

            wait_req_ready();
            req_valid = 1'b1;
            req_write = (kind == 0);
            req_addr  = 11'(addr);
            req_data  = 8'(data);
            refuse    = (mnack != 0);
            rsp_ready = (count % 4 != 2);  // some lines get back-pressure
            @(negedge CLK);
            req_valid = 1'b0;

            wait_rsp_valid();
            held_data = rsp_data;
            held_nack = rsp_nack;
            if (!rsp_ready) begin
                repeat (20) begin
                    @(negedge CLK);
                    check_value(32'(rsp_valid), 1, "rsp_valid held");
                    check_value(32'(rsp_data), 32'(held_data), "rsp_data held");
                    check_value(32'(rsp_nack), 32'(held_nack), "rsp_nack held");
                    check_value(32'(req_ready), 0, "req_ready while responding");
                end
                rsp_ready = 1'b1;
            end

            check_value(32'(held_data), exp_data, "rsp_data");
            check_value(32'(held_nack), exp_nack, "rsp_nack");
            check_value(32'(scl), 1, "scl idle after transfer");
            check_value(32'(sda_low), 0, "sda_low idle after transfer");
            check_value(32'(in_frame), 0, "stop seen by the model");
            check_value(32'(code_err), 0, "device code seen by the model");
            check_value(frame_starts, count + 1, "start conditions seen by the model");

            if (kind == 0 && mnack == 0)
                ref_mem[11'(addr)] = 8'(data);
            count++;
        end
        $fclose(fd);

        if (count == 0) begin
            $display("no request could be read from the stimulus file");
            $display("TEST FAIL");
            $fatal(1);
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
